// ==== verilog/wb_pkg.sv ====
package wb_pkg;

    // basic data widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;

    // APB word index width on the read-back port
    localparam int APB_ADDR_W = 8;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    // what a retiring instruction does to architectural state
    typedef enum logic [2:0] {
        WB_NONE = 3'd0,
        WB_REG  = 3'd1,
        WB_MTHI = 3'd2,
        WB_MTLO = 3'd3,
        WB_MULT = 3'd4,
        WB_MADD = 3'd5,
        WB_MSUB = 3'd6
    } wb_op_e;

    // one retiring instruction
    typedef struct packed {
        logic      valid;
        wb_op_e    op;
        reg_addr_t rdst;
        word_t     wd;
        dword_t    hilo;
    } retire_slot_t;

    // [1] is the older slot, [0] the younger
    typedef retire_slot_t [1:0] retire_pair_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_resp_t;

    typedef enum logic [1:0] {
        APB_IDLE = 2'd0,
        APB_WAIT = 2'd1,
        APB_DONE = 2'd2
    } apb_state_e;

endpackage

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps

module regfile #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  wb_pkg::retire_pair_t  i_retire,
    input  logic [REG_ADDR_W-1:0] i_ra,
    output wb_pkg::word_t         o_rd
);
    import wb_pkg::*;

    localparam int NREG = 1 << REG_ADDR_W;

    word_t      regs [NREG];
    logic [1:0] we;

    // register writes per slot, r0 never written
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            we[s] = i_retire[s].valid && (i_retire[s].op == WB_REG)
                    && (i_retire[s].rdst != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // older slot first so the younger one lands last
            for (int s = 1; s >= 0; s--) begin
                if (we[s]) begin
                    regs[i_retire[s].rdst] <= i_retire[s].wd;
                end
            end
        end
    end

    assign o_rd = regs[i_ra];

    // decode upstream must never mark an empty slot valid
    a_valid_has_op: assert property (@(posedge clk) disable iff (reset)
        (i_retire[0].valid -> i_retire[0].op != WB_NONE)
        && (i_retire[1].valid -> i_retire[1].op != WB_NONE));

    a_r0_zero: assert property (@(posedge clk) disable iff (reset)
        (i_ra == '0) |-> (o_rd == '0));

endmodule

// ==== verilog/hilo_unit.sv ====
`timescale 1ns/10ps

module hilo_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_pkg::retire_pair_t i_retire,
    output wb_pkg::word_t        o_hi,
    output wb_pkg::word_t        o_lo
);
    import wb_pkg::*;

    word_t hi_q;
    word_t lo_q;
    word_t hi_next;
    word_t lo_next;

    // walk older to younger, later slot overrides per half
    always_comb begin
        dword_t acc;

        hi_next = hi_q;
        lo_next = lo_q;
        acc     = '0;
        for (int s = 1; s >= 0; s--) begin
            if (i_retire[s].valid) begin
                case (i_retire[s].op)
                    WB_MTHI: begin
                        hi_next = i_retire[s].wd;
                    end
                    WB_MTLO: begin
                        lo_next = i_retire[s].wd;
                    end
                    WB_MULT: begin
                        hi_next = i_retire[s].hilo[63:32];
                        lo_next = i_retire[s].hilo[31:0];
                    end
                    WB_MADD: begin
                        // pre-edge hi:lo, no chaining between slots
                        acc     = {hi_q, lo_q} + i_retire[s].hilo;
                        hi_next = acc[63:32];
                        lo_next = acc[31:0];
                    end
                    WB_MSUB: begin
                        acc     = {hi_q, lo_q} - i_retire[s].hilo;
                        hi_next = acc[63:32];
                        lo_next = acc[31:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            hi_q <= hi_next;
            lo_q <= lo_next;
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

    // a lone younger mult fully replaces hi:lo one cycle later
    a_mult_load: assert property (@(posedge clk) disable iff (reset)
        (i_retire[0].valid && (i_retire[0].op == WB_MULT) && !i_retire[1].valid)
        |=> ({hi_q, lo_q} == $past(i_retire[0].hilo)));

endmodule

// ==== verilog/apb_readout.sv ====
`timescale 1ns/10ps

module apb_readout #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  wb_pkg::apb_req_t      i_apb,
    input  wb_pkg::word_t         i_rd,
    input  wb_pkg::word_t         i_hi,
    input  wb_pkg::word_t         i_lo,
    output logic [REG_ADDR_W-1:0] o_ra,
    output wb_pkg::apb_resp_t     o_apb
);
    import wb_pkg::*;

    localparam int NREG    = 1 << REG_ADDR_W;
    localparam int HI_ADDR = NREG;
    localparam int LO_ADDR = NREG + 1;

    apb_state_e state_q;
    logic       sel_reg;
    logic       sel_hi;
    logic       sel_lo;
    logic       err;
    word_t      rdata;
    word_t      rdata_q;
    logic       err_q;

    // address decode, valid while paddr is held in the access phase
    always_comb begin
        sel_reg = int'(i_apb.paddr) < NREG;
        sel_hi  = int'(i_apb.paddr) == HI_ADDR;
        sel_lo  = int'(i_apb.paddr) == LO_ADDR;
        err     = i_apb.pwrite || !(sel_reg || sel_hi || sel_lo);
        if (err) begin
            rdata = '0;
        end else if (sel_hi) begin
            rdata = i_hi;
        end else if (sel_lo) begin
            rdata = i_lo;
        end else begin
            rdata = i_rd;
        end
    end

    assign o_ra = i_apb.paddr[REG_ADDR_W-1:0];

    // setup -> wait (capture) -> done (pready)
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= APB_IDLE;
        end else begin
            case (state_q)
                APB_IDLE: begin
                    if (i_apb.psel && !i_apb.penable) begin
                        state_q <= APB_WAIT;
                    end
                end
                APB_WAIT: begin
                    // requester gave up the transfer
                    state_q <= (i_apb.psel && i_apb.penable) ? APB_DONE : APB_IDLE;
                end
                default: begin
                    state_q <= APB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == APB_WAIT) begin
            rdata_q <= rdata;
            err_q   <= err;
        end
    end

    always_comb begin
        o_apb.prdata  = rdata_q;
        o_apb.pready  = (state_q == APB_DONE);
        o_apb.pslverr = (state_q == APB_DONE) && err_q;
    end

    a_penable_after_psel: assert property (@(posedge clk) disable iff (reset)
        $rose(i_apb.penable) |-> $past(i_apb.psel));

    a_paddr_held: assert property (@(posedge clk) disable iff (reset)
        (i_apb.psel && i_apb.penable && !o_apb.pready) |=> $stable(i_apb.paddr));

endmodule

// ==== verilog/wb_top.sv ====
`timescale 1ns/10ps

module wb_top #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_pkg::retire_pair_t i_retire,
    input  wb_pkg::apb_req_t     i_apb,
    output wb_pkg::apb_resp_t    o_apb
);
    import wb_pkg::*;

    logic [REG_ADDR_W-1:0] ra;
    word_t                 rd;
    word_t                 hi;
    word_t                 lo;

    regfile #(
        .REG_ADDR_W(REG_ADDR_W)
    ) regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .i_retire (i_retire),
        .i_ra     (ra),
        .o_rd     (rd)
    );

    hilo_unit hilo_inst (
        .clk      (clk),
        .reset    (reset),
        .i_retire (i_retire),
        .o_hi     (hi),
        .o_lo     (lo)
    );

    // read-back path for the register file and hi/lo
    apb_readout #(
        .REG_ADDR_W(REG_ADDR_W)
    ) apb_inst (
        .clk   (clk),
        .reset (reset),
        .i_apb (i_apb),
        .i_rd  (rd),
        .i_hi  (hi),
        .i_lo  (lo),
        .o_ra  (ra),
        .o_apb (o_apb)
    );

endmodule

// ==== verification/wb_checker.sv ====
`timescale 1ns/10ps

module wb_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_pkg::retire_pair_t i_retire,
    input  wb_pkg::apb_req_t     i_apb,
    input  wb_pkg::apb_resp_t    i_resp,
    input  logic                 i_exp_err,
    input  logic                 i_done,
    output int                   o_errors
);
    import wb_pkg::*;

    word_t      regs [32];
    word_t      hi;
    word_t      lo;
    apb_state_e state;
    logic [7:0] want_addr;
    word_t      want_data;
    logic       want_err;
    int         reads = 0;
    int         data_errs = 0;
    int         resp_errs = 0;
    int         proto_errs = 0;

    assign o_errors = data_errs + resp_errs + proto_errs;

    function automatic logic hits_hi(input retire_slot_t s);
        return s.valid && (s.op inside {WB_MTHI, WB_MULT, WB_MADD, WB_MSUB});
    endfunction

    function automatic logic hits_lo(input retire_slot_t s);
        return s.valid && (s.op inside {WB_MTLO, WB_MULT, WB_MADD, WB_MSUB});
    endfunction

    // full hi:lo a slot would leave if it were alone
    function automatic dword_t slot_effect(input retire_slot_t s, input dword_t old);
        case (s.op)
            WB_MTHI: return {s.wd, old[31:0]};
            WB_MTLO: return {old[63:32], s.wd};
            WB_MULT: return s.hilo;
            WB_MADD: return old + s.hilo;
            WB_MSUB: return old - s.hilo;
            default: return old;
        endcase
    endfunction

    function automatic word_t model_read(input logic [7:0] a);
        if (a < 8'd32) begin
            return regs[a[4:0]];
        end
        return (a == 8'd32) ? hi : ((a == 8'd33) ? lo : '0);
    endfunction

    task automatic update_model();
        dword_t old;
        dword_t e0;
        dword_t e1;
        old = {hi, lo};
        e0  = slot_effect(i_retire[0], old);
        e1  = slot_effect(i_retire[1], old);
        // younger slot checked first for each half
        if (hits_hi(i_retire[0])) begin
            hi = e0[63:32];
        end else if (hits_hi(i_retire[1])) begin
            hi = e1[63:32];
        end
        if (hits_lo(i_retire[0])) begin
            lo = e0[31:0];
        end else if (hits_lo(i_retire[1])) begin
            lo = e1[31:0];
        end
        for (int s = 1; s >= 0; s--) begin
            if (i_retire[s].valid && i_retire[s].op == WB_REG && i_retire[s].rdst != 5'd0) begin
                regs[i_retire[s].rdst] = i_retire[s].wd;
            end
        end
    endtask

    task automatic check_response();
        if (i_resp.pready !== (state == APB_DONE)) begin
            $display("error t=%0t pready: got %b expected %b (state %s)",
                     $time, i_resp.pready, state == APB_DONE, state.name());
            proto_errs++;
        end
        if (state == APB_DONE) begin
            reads++;
            if (i_resp.pslverr !== want_err) begin
                $display("error t=%0t pslverr: got %b expected %b (addr %0d)",
                         $time, i_resp.pslverr, want_err, want_addr);
                resp_errs++;
            end else if (!want_err && i_resp.prdata !== want_data) begin
                $display("error t=%0t prdata: got %h expected %h (addr %0d)",
                         $time, i_resp.prdata, want_data, want_addr);
                data_errs++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            hi    = '0;
            lo    = '0;
            state = APB_IDLE;
        end else begin
            check_response();
            case (state)
                APB_IDLE: begin
                    if (i_apb.psel && !i_apb.penable) begin
                        state = APB_WAIT;
                    end
                end
                APB_WAIT: begin
                    // expected read data taken at the capture edge
                    want_addr = i_apb.paddr;
                    want_data = model_read(i_apb.paddr);
                    want_err  = i_exp_err;
                    state     = (i_apb.psel && i_apb.penable) ? APB_DONE : APB_IDLE;
                end
                default: begin
                    state = APB_IDLE;
                end
            endcase
            update_model();
        end
    end

    always @(posedge i_done) begin
        $display("checks: reads=%0d data_errors=%0d resp_errors=%0d protocol_errors=%0d",
                 reads, data_errs, resp_errs, proto_errs);
    end

endmodule

// ==== verification/wb_tb.sv ====
`timescale 1ns/10ps

module wb_tb;
    import wb_pkg::*;

    localparam int NROWS      = 37;
    localparam int MAX_CYCLES = NROWS * 6 + 50;

    // a table row holds a retire pair or an APB access
    typedef struct packed {
        logic       is_apb;
        wb_op_e     op1;
        logic [4:0] rd1;
        wb_op_e     op0;
        logic [4:0] rd0;
        logic [7:0] addr;
        logic       wr;
        logic       exp_slverr;
    } row_t;

    logic         clk;
    logic         reset;
    retire_pair_t retire;
    apb_req_t     apb_req;
    apb_resp_t    apb_resp;
    logic         exp_err;
    logic         done;
    int           errors;
    logic [31:0]  rng;
    row_t         rows [NROWS];

    wb_top #(
        .REG_ADDR_W(5)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .i_retire (retire),
        .i_apb    (apb_req),
        .o_apb    (apb_resp)
    );

    wb_checker checker_inst (
        .clk       (clk),
        .reset     (reset),
        .i_retire  (retire),
        .i_apb     (apb_req),
        .i_resp    (apb_resp),
        .i_exp_err (exp_err),
        .i_done    (done),
        .o_errors  (errors)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic build_slot(input wb_op_e op, input logic [4:0] rd, output retire_slot_t s);
        s.valid = (op != WB_NONE);
        s.op    = op;
        s.rdst  = rd;
        rng     = xorshift32(rng);
        s.wd    = rng;
        rng     = xorshift32(rng);
        s.hilo[63:32] = rng;
        rng     = xorshift32(rng);
        s.hilo[31:0]  = rng;
    endtask

    // retire for one cycle, then one idle cycle
    task automatic retire_step(input row_t r);
        retire_slot_t s1;
        retire_slot_t s0;
        build_slot(r.op1, r.rd1, s1);
        build_slot(r.op0, r.rd0, s0);
        @(negedge clk);
        retire[1] = s1;
        retire[0] = s0;
        @(negedge clk);
        retire = '0;
    endtask

    task automatic apb_access(input row_t r);
        @(negedge clk);
        rng             = xorshift32(rng);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = r.wr;
        apb_req.paddr   = r.addr;
        apb_req.pwdata  = rng;
        exp_err         = r.exp_slverr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!apb_resp.pready);
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // addr 32 is HI, 33 is LO
    task automatic load_table();
        rows[0]  = '{1'b0, WB_NONE, 5'd0, WB_REG, 5'd5, 8'd0, 1'b0, 1'b0};
        rows[1]  = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd5, 1'b0, 1'b0};
        rows[2]  = '{1'b0, WB_REG, 5'd17, WB_REG, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[3]  = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[4]  = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd17, 1'b0, 1'b0};
        rows[5]  = '{1'b0, WB_REG, 5'd9, WB_REG, 5'd9, 8'd0, 1'b0, 1'b0};
        rows[6]  = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd9, 1'b0, 1'b0};
        rows[7]  = '{1'b0, WB_REG, 5'd3, WB_REG, 5'd4, 8'd0, 1'b0, 1'b0};
        rows[8]  = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd3, 1'b0, 1'b0};
        rows[9]  = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd4, 1'b0, 1'b0};
        rows[10] = '{1'b0, WB_NONE, 5'd0, WB_MTHI, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[11] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[12] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        rows[13] = '{1'b0, WB_NONE, 5'd0, WB_MTLO, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[14] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        rows[15] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[16] = '{1'b0, WB_NONE, 5'd0, WB_MULT, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[17] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[18] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        rows[19] = '{1'b0, WB_MTHI, 5'd0, WB_MTHI, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[20] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[21] = '{1'b0, WB_NONE, 5'd0, WB_MADD, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[22] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[23] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        rows[24] = '{1'b0, WB_NONE, 5'd0, WB_MSUB, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[25] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[26] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        rows[27] = '{1'b0, WB_MADD, 5'd0, WB_MADD, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[28] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[29] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        rows[30] = '{1'b0, WB_MULT, 5'd0, WB_MADD, 5'd0, 8'd0, 1'b0, 1'b0};
        rows[31] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd32, 1'b0, 1'b0};
        rows[32] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd33, 1'b0, 1'b0};
        // write and out-of-range accesses, then a read that must be unchanged
        rows[33] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd5, 1'b1, 1'b1};
        rows[34] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd40, 1'b0, 1'b1};
        rows[35] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd5, 1'b0, 1'b0};
        rows[36] = '{1'b1, WB_NONE, 5'd0, WB_NONE, 5'd0, 8'd34, 1'b0, 1'b1};
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        retire  = '0;
        apb_req = '0;
        exp_err = 1'b0;
        done    = 1'b0;
        rng     = 32'd76;
        load_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NROWS; i++) begin
            if (rows[i].is_apb) begin
                apb_access(rows[i]);
            end else begin
                retire_step(rows[i]);
            end
        end
        @(negedge clk);
        done = 1'b1;
        #1;
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== wb_core.f ====
verilog/wb_pkg.sv
verilog/regfile.sv
verilog/hilo_unit.sv
verilog/apb_readout.sv
verilog/wb_top.sv
verification/wb_checker.sv
verification/wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f wb_core.f --top-module wb_tb -o wb_sim

./obj_dir/wb_sim | tee sim.log

if grep -q "Simulation passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
